/* logic/mm_pkg.sv */
// Matrix multiply controller definitions
`default_nettype none

package mm_pkg;

  // Memory address width
  localparam int ADDR_W = 32;

  // Largest matrix side handled by one job
  localparam int MAX_LEN = 256;

  // Tile side and its log2
  localparam int TILE = 4;
  localparam int TILE_SHIFT = $clog2(TILE);

  // Matrix side L up to MAX_LEN inclusive
  localparam int LEN_W = $clog2(MAX_LEN + 1);

  // Tiles along one side as T = L / TILE
  localparam int TILE_CNT_W = $clog2((MAX_LEN >> TILE_SHIFT) + 1);

  // Tile pairs per job as T * T
  localparam int PAIR_CNT_W = $clog2((MAX_LEN >> TILE_SHIFT) * (MAX_LEN >> TILE_SHIFT) + 1);

  // One job as handed in by the host
  typedef struct packed {
    logic [ADDR_W-1:0] a_base;
    logic [ADDR_W-1:0] b_base;
    logic [ADDR_W-1:0] c_base;
    logic [LEN_W-1:0]  length;
  } mm_command_t;

  // Strip instruction to an input buffer
  typedef struct packed {
    logic [ADDR_W-1:0]     addr;
    logic [LEN_W-1:0]      length;
    logic [TILE_CNT_W-1:0] repeats;
  } operand_instr_t;

  // Description of one operand stream
  typedef struct packed {
    // First strip address
    logic [ADDR_W-1:0]     base;
    // Address step from one strip to the next
    logic [ADDR_W-1:0]     stride;
    // Instructions to send in this job
    logic [PAIR_CNT_W-1:0] count;
    // Strips before the index goes back to zero
    logic [TILE_CNT_W-1:0] wrap;
    logic [LEN_W-1:0]      length;
    logic [TILE_CNT_W-1:0] repeats;
  } operand_plan_t;

  // Description of the result stream
  typedef struct packed {
    logic [ADDR_W-1:0]     c_base;
    logic [PAIR_CNT_W-1:0] tile_pairs;
  } result_plan_t;

endpackage

`default_nettype wire

/* logic/mm_command_decoder.sv */
// Command decode stage
`timescale 1ns/10ps
`default_nettype none

module mm_command_decoder (
  input  logic                  clk,
  input  logic                  reset,
  input  mm_pkg::mm_command_t   cmd,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  logic                  job_end,
  output logic                  done,
  output logic                  start,
  output mm_pkg::operand_plan_t a_plan,
  output mm_pkg::operand_plan_t b_plan,
  output mm_pkg::result_plan_t  r_plan
);

  // Command held for the whole job
  mm_pkg::mm_command_t cmd_q;

  logic busy;
  logic accept;

  // Derived job sizes
  logic [mm_pkg::TILE_CNT_W-1:0] tile_cnt;
  logic [mm_pkg::PAIR_CNT_W-1:0] tile_pairs;
  logic [mm_pkg::ADDR_W-1:0]     strip_stride;

  // Only one job in flight
  assign cmd_ready = ~busy;
  assign accept = cmd_valid & cmd_ready;

  // Command register loads on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
  end

  // Busy and done levels and the start pulse
  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      done <= 1'b0;
      start <= 1'b0;
    end else begin
      // Stages load their plans one cycle after acceptance
      start <= accept;
      if (accept) begin
        busy <= 1'b1;
        done <= 1'b0;
      end else if (job_end) begin
        // Last tile of C reported written
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  // T = L / TILE as a shift
  assign tile_cnt = mm_pkg::TILE_CNT_W'(cmd_q.length >> mm_pkg::TILE_SHIFT);
  assign tile_pairs = mm_pkg::PAIR_CNT_W'(tile_cnt) * mm_pkg::PAIR_CNT_W'(tile_cnt);

  // One strip is TILE rows of L elements
  assign strip_stride = mm_pkg::ADDR_W'(cmd_q.length) << mm_pkg::TILE_SHIFT;

  // A strips go out once each
  // Every A strip is replayed against all T B strips
  assign a_plan.base = cmd_q.a_base;
  assign a_plan.stride = strip_stride;
  assign a_plan.count = mm_pkg::PAIR_CNT_W'(tile_cnt);
  assign a_plan.wrap = tile_cnt;
  assign a_plan.length = cmd_q.length;
  assign a_plan.repeats = tile_cnt;

  // B strips cycle once per A strip
  assign b_plan.base = cmd_q.b_base;
  assign b_plan.stride = strip_stride;
  assign b_plan.count = tile_pairs;
  assign b_plan.wrap = tile_cnt;
  assign b_plan.length = cmd_q.length;
  assign b_plan.repeats = mm_pkg::TILE_CNT_W'(1);

  // One C tile per A and B strip pair
  assign r_plan.c_base = cmd_q.c_base;
  assign r_plan.tile_pairs = tile_pairs;

endmodule

`default_nettype wire

/* logic/operand_issuer.sv */
// Operand strip issuer
`timescale 1ns/10ps
`default_nettype none

module operand_issuer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   start,
  input  mm_pkg::operand_plan_t  plan,
  output mm_pkg::operand_instr_t instr,
  output logic                   valid,
  input  logic                   ready
);

  // Instructions still to send
  logic [mm_pkg::PAIR_CNT_W-1:0] remaining;

  // Current strip within the wrap period
  logic [mm_pkg::TILE_CNT_W-1:0] strip_idx;
  logic [mm_pkg::TILE_CNT_W-1:0] next_idx;

  // Address of the instruction on offer
  logic [mm_pkg::ADDR_W-1:0] addr_q;

  logic xfer;
  logic wrap_now;

  // Stream drains to zero then stays quiet
  assign valid = (remaining != '0);
  assign xfer = valid & ready;

  // Strip index wraps back to the first strip
  assign next_idx = strip_idx + 1'b1;
  assign wrap_now = (next_idx == plan.wrap);

  // Instruction counter and strip index
  always_ff @(posedge clk) begin
    if (reset) begin
      remaining <= '0;
      strip_idx <= '0;
    end else if (start) begin
      remaining <= plan.count;
      strip_idx <= '0;
    end else if (xfer) begin
      remaining <= remaining - 1'b1;
      if (wrap_now) begin
        strip_idx <= '0;
      end else begin
        strip_idx <= next_idx;
      end
    end
  end

  // Strip address follows the index
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= plan.base;
    end else if (xfer) begin
      if (wrap_now) begin
        // Back to the first strip of the operand
        addr_q <= plan.base;
      end else begin
        addr_q <= addr_q + plan.stride;
      end
    end
  end

  // Length and repeats are fixed for the job
  // Plan holds steady while the job runs
  assign instr.addr = addr_q;
  assign instr.length = plan.length;
  assign instr.repeats = plan.repeats;

endmodule

`default_nettype wire

/* logic/result_writeback_ctrl.sv */
// Result tile issue and completion tracking
`timescale 1ns/10ps
`default_nettype none

module result_writeback_ctrl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  mm_pkg::result_plan_t      plan,
  output logic [mm_pkg::ADDR_W-1:0] c_addr,
  output logic                      c_valid,
  input  logic                      c_ready,
  input  logic                      tile_done_valid,
  output logic                      tile_done_ready,
  output logic                      job_end
);

  // Address step between C tiles
  localparam logic [mm_pkg::ADDR_W-1:0] TILE_STEP = mm_pkg::ADDR_W'(mm_pkg::TILE * mm_pkg::TILE);

  // Tile addresses still to hand out
  logic [mm_pkg::PAIR_CNT_W-1:0] issue_left;

  // Completion reports still expected
  logic [mm_pkg::PAIR_CNT_W-1:0] done_left;

  logic [mm_pkg::ADDR_W-1:0] addr_q;

  logic c_xfer;
  logic report;

  // Issue side mirrors the operand streams
  assign c_valid = (issue_left != '0);
  assign c_xfer = c_valid & c_ready;
  assign c_addr = addr_q;

  // Accept reports only while some are outstanding
  assign tile_done_ready = (done_left != '0);
  assign report = tile_done_valid & tile_done_ready;

  // Tile issue counter
  always_ff @(posedge clk) begin
    if (reset) begin
      issue_left <= '0;
    end else if (start) begin
      issue_left <= plan.tile_pairs;
    end else if (c_xfer) begin
      issue_left <= issue_left - 1'b1;
    end
  end

  // Tile addresses in row major order
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= plan.c_base;
    end else if (c_xfer) begin
      addr_q <= addr_q + TILE_STEP;
    end
  end

  // Completion counter runs apart from issue progress
  // Reports may overlap with later tile issues
  always_ff @(posedge clk) begin
    if (reset) begin
      done_left <= '0;
    end else if (start) begin
      done_left <= plan.tile_pairs;
    end else if (report) begin
      done_left <= done_left - 1'b1;
    end
  end

  // Job end one cycle after the final report
  always_ff @(posedge clk) begin
    if (reset) begin
      job_end <= 1'b0;
    end else if (start) begin
      // Empty job ends straight away
      job_end <= (plan.tile_pairs == '0);
    end else begin
      job_end <= report && (done_left == mm_pkg::PAIR_CNT_W'(1));
    end
  end

endmodule

`default_nettype wire

/* logic/mm_controller.sv */
// Tiled matrix multiply controller
`timescale 1ns/10ps
`default_nettype none

module mm_controller (
  input  logic                      clk,
  input  logic                      reset,

  // Host command
  input  mm_pkg::mm_command_t       cmd,
  input  logic                      cmd_valid,
  output logic                      cmd_ready,

  // A input buffer
  output mm_pkg::operand_instr_t    a_instr,
  output logic                      a_valid,
  input  logic                      a_ready,

  // B input buffer
  output mm_pkg::operand_instr_t    b_instr,
  output logic                      b_valid,
  input  logic                      b_ready,

  // Output writer tile addresses
  output logic [mm_pkg::ADDR_W-1:0] c_addr,
  output logic                      c_valid,
  input  logic                      c_ready,

  // Output writer completion reports
  input  logic                      tile_done_valid,
  output logic                      tile_done_ready,

  // Job finished level
  output logic                      done
);

  logic start;
  logic job_end;

  mm_pkg::operand_plan_t a_plan;
  mm_pkg::operand_plan_t b_plan;
  mm_pkg::result_plan_t  r_plan;

  // Decode stage owns busy and done
  mm_command_decoder decode (
    .clk       (clk),
    .reset     (reset),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .job_end   (job_end),
    .done      (done),
    .start     (start),
    .a_plan    (a_plan),
    .b_plan    (b_plan),
    .r_plan    (r_plan)
  );

  // A strips
  operand_issuer a_issue (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .plan  (a_plan),
    .instr (a_instr),
    .valid (a_valid),
    .ready (a_ready)
  );

  // B strips replayed per A strip
  operand_issuer b_issue (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .plan  (b_plan),
    .instr (b_instr),
    .valid (b_valid),
    .ready (b_ready)
  );

  // C tiles and completion count
  result_writeback_ctrl result (
    .clk             (clk),
    .reset           (reset),
    .start           (start),
    .plan            (r_plan),
    .c_addr          (c_addr),
    .c_valid         (c_valid),
    .c_ready         (c_ready),
    .tile_done_valid (tile_done_valid),
    .tile_done_ready (tile_done_ready),
    .job_end         (job_end)
  );

endmodule

`default_nettype wire

/* dv/mm_controller_properties.sv */
// Matrix multiply controller properties
`timescale 1ns/10ps
`default_nettype none

module mm_controller_properties (
  input logic                      clk,
  input logic                      reset,
  input mm_pkg::operand_instr_t    a_instr,
  input logic                      a_valid,
  input logic                      a_ready,
  input mm_pkg::operand_instr_t    b_instr,
  input logic                      b_valid,
  input logic                      b_ready,
  input logic [mm_pkg::ADDR_W-1:0] c_addr,
  input logic                      c_valid,
  input logic                      c_ready,
  input logic                      tile_done_valid,
  input logic                      tile_done_ready,
  input logic                      done
);

  // Number of failed properties
  int unsigned failures = 0;

  // Stalled A instruction stays put
  a_hold: assert property (@(posedge clk) disable iff (reset)
      a_valid && !a_ready |=> a_valid && $stable(a_instr))
    else begin
      $error("A instruction changed while stalled");
      failures++;
    end

  // Same for B
  b_hold: assert property (@(posedge clk) disable iff (reset)
      b_valid && !b_ready |=> b_valid && $stable(b_instr))
    else begin
      $error("B instruction changed while stalled");
      failures++;
    end

  c_hold: assert property (@(posedge clk) disable iff (reset)
      c_valid && !c_ready |=> c_valid && $stable(c_addr))
    else begin
      $error("C tile address changed while stalled");
      failures++;
    end

  // Finished job leaves every stream quiet
  done_quiet: assert property (@(posedge clk) disable iff (reset)
      done |-> !a_valid && !b_valid && !c_valid && !tile_done_ready)
    else begin
      $error("stream still active while done is high");
      failures++;
    end

  // done follows the last counted report
  done_after_report: assert property (@(posedge clk) disable iff (reset)
      $rose(done) |-> $past(tile_done_valid && tile_done_ready, 2))
    else begin
      $error("done rose without a completion just before");
      failures++;
    end

endmodule

bind mm_controller mm_controller_properties props (.*);

`default_nettype wire

/* dv/mm_controller_tb.sv */
// Matrix multiply controller testbench
`timescale 1ns/10ps
`default_nettype none

module mm_controller_tb;

  // Job list where the last two run back to back
  localparam int NUM_JOBS = 5;
  localparam int JOB_LEN [NUM_JOBS] = '{4, 8, 16, 8, 4};
  localparam logic [31:0] JOB_A [NUM_JOBS] =
    '{32'h0000_1000, 32'h0002_0000, 32'h0010_0400, 32'h0300_0000, 32'h0000_0040};
  localparam logic [31:0] JOB_B [NUM_JOBS] =
    '{32'h0000_2000, 32'h0004_0000, 32'h0020_0800, 32'h0310_0000, 32'h0000_0080};
  localparam logic [31:0] JOB_C [NUM_JOBS] =
    '{32'h0000_3000, 32'h0008_0000, 32'h0040_0c00, 32'h0320_0000, 32'h0000_00c0};

  logic clk;
  logic reset;
  mm_pkg::mm_command_t cmd;
  logic cmd_valid;
  logic cmd_ready;
  mm_pkg::operand_instr_t a_instr;
  logic a_valid;
  logic a_ready;
  mm_pkg::operand_instr_t b_instr;
  logic b_valid;
  logic b_ready;
  logic [mm_pkg::ADDR_W-1:0] c_addr;
  logic c_valid;
  logic c_ready;
  logic tile_done_valid;
  logic tile_done_ready;
  logic done;

  logic [31:0] rng_state;
  int err_count;
  int tests_passed;
  int tests_failed;
  int jobs_finished;

  // Expected job shape latched when the command is taken
  bit job_open;
  int exp_len;
  int exp_tiles;
  logic [31:0] exp_a_base;
  logic [31:0] exp_b_base;
  logic [31:0] exp_c_base;
  int a_count;
  int b_count;
  int c_count;
  int report_count;

  // C tiles handed to the writer and not yet reported
  logic [31:0] c_queue [$];

  mm_controller mm_controller_inst (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Local checks plus bound property failures
  function automatic int total_errors();
    return err_count + mm_controller_inst.props.failures;
  endfunction

  // 40 cycles per tile pair and 100 per job
  function automatic int watchdog_cycles();
    int total;
    int t;
    total = 20;
    for (int i = 0; i < NUM_JOBS; i++) begin
      t = JOB_LEN[i] / mm_pkg::TILE;
      total += 40 * t * t + 100;
    end
    return total;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else begin
        $display("mismatch %s expected %h got %h", name, expected, actual);
        err_count++;
      end
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (total_errors() == errs_before) begin
      tests_passed++;
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed", name);
    end
  endtask

  // Offer one command and hold it until taken
  task automatic send_cmd(input int idx);
    @(negedge clk);
    cmd.a_base = JOB_A[idx];
    cmd.b_base = JOB_B[idx];
    cmd.c_base = JOB_C[idx];
    cmd.length = mm_pkg::LEN_W'(JOB_LEN[idx]);
    cmd_valid = 1'b1;
    @(posedge clk);
    while (!cmd_ready) @(posedge clk);
  endtask

  task automatic run_jobs(input string name, input int first, input int num);
    int errs_before;
    int target;
    errs_before = total_errors();
    target = jobs_finished + num;
    // Next command waits behind the running job
    for (int i = first; i < first + num; i++) begin
      send_cmd(i);
    end
    @(negedge clk);
    cmd_valid = 1'b0;
    wait (jobs_finished == target);
    end_test(name, errs_before);
  endtask

  // Random readies and writer reports
  always @(negedge clk) begin
    rng_state = xorshift(rng_state);
    a_ready = rng_state[0];
    b_ready = rng_state[1] | rng_state[2];
    c_ready = rng_state[4];
    // A tile finishes only once its A and B strips were consumed
    tile_done_valid = (c_queue.size() > 0) && rng_state[7] &&
                      (b_count > report_count) && (a_count * exp_tiles > report_count);
  end

  // Scoreboard sampled on the rising edge
  always @(posedge clk) begin
    logic [31:0] stride;
    if (!reset) begin
      stride = exp_len * mm_pkg::TILE;
      // Host is held off while a job runs
      if (job_open && !done) begin
        check_value("cmd_ready", 0, cmd_ready);
      end
      assert (job_open || !(a_valid || b_valid || c_valid))
        else begin
          $display("instruction offered while no job was running");
          err_count++;
        end
      if (job_open && a_valid && a_ready) begin
        check_value("a_instr.addr", exp_a_base + a_count * stride, a_instr.addr);
        check_value("a_instr.length", exp_len, a_instr.length);
        check_value("a_instr.repeats", exp_tiles, a_instr.repeats);
        a_count++;
      end
      // B strips cycle once per A strip
      if (job_open && b_valid && b_ready) begin
        check_value("b_instr.addr", exp_b_base + (b_count % exp_tiles) * stride, b_instr.addr);
        check_value("b_instr.length", exp_len, b_instr.length);
        check_value("b_instr.repeats", 1, b_instr.repeats);
        b_count++;
      end
      if (job_open && c_valid && c_ready) begin
        check_value("c_addr", exp_c_base + c_count * 16, c_addr);
        c_queue.push_back(c_addr);
        c_count++;
      end
      if (tile_done_valid && tile_done_ready && c_queue.size() > 0) begin
        void'(c_queue.pop_front());
        report_count++;
      end
      // Job closes on the first sampled done
      if (job_open && done) begin
        check_value("a transfers", exp_tiles, a_count);
        check_value("b transfers", exp_tiles * exp_tiles, b_count);
        check_value("c transfers", exp_tiles * exp_tiles, c_count);
        check_value("completions", exp_tiles * exp_tiles, report_count);
        job_open = 1'b0;
        jobs_finished++;
      end
      if (cmd_valid && cmd_ready) begin
        exp_len = cmd.length;
        exp_tiles = cmd.length / mm_pkg::TILE;
        exp_a_base = cmd.a_base;
        exp_b_base = cmd.b_base;
        exp_c_base = cmd.c_base;
        a_count = 0;
        b_count = 0;
        c_count = 0;
        report_count = 0;
        job_open = 1'b1;
      end
    end
  end

  initial begin
    repeat (watchdog_cycles()) @(posedge clk);
    $display("watchdog expired before all jobs finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int errs_before;
    clk = 1'b0;
    reset = 1'b1;
    cmd = '0;
    cmd_valid = 1'b0;
    a_ready = 1'b0;
    b_ready = 1'b0;
    c_ready = 1'b0;
    tile_done_valid = 1'b0;
    rng_state = 32'h8f99726a;
    err_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    jobs_finished = 0;
    job_open = 1'b0;
    exp_tiles = 0;
    a_count = 0;
    b_count = 0;
    report_count = 0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    // Idle levels right after reset
    errs_before = total_errors();
    @(posedge clk);
    check_value("a_valid", 0, a_valid);
    check_value("b_valid", 0, b_valid);
    check_value("c_valid", 0, c_valid);
    check_value("tile_done_ready", 0, tile_done_ready);
    check_value("done", 0, done);
    check_value("cmd_ready", 1, cmd_ready);
    end_test("reset_state", errs_before);
    run_jobs("job_l4", 0, 1);
    run_jobs("job_l8", 1, 1);
    run_jobs("job_l16", 2, 1);
    run_jobs("back_to_back", 3, 2);
    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
logic/mm_pkg.sv
logic/mm_command_decoder.sv
logic/operand_issuer.sv
logic/result_writeback_ctrl.sv
logic/mm_controller.sv
dv/mm_controller_properties.sv
dv/mm_controller_tb.sv

/* Bender.yml */
package:
  name: mm_controller

sources:
  - logic/mm_pkg.sv
  - logic/mm_command_decoder.sv
  - logic/operand_issuer.sv
  - logic/result_writeback_ctrl.sv
  - logic/mm_controller.sv
  - target: test
    files:
      - dv/mm_controller_properties.sv
      - dv/mm_controller_tb.sv
